//--- ccm_mem.f
+incdir+hdl
hdl/ccm_pkg.sv
hdl/ccm_bank.sv
hdl/ccm_dccm_mem.sv
hdl/ccm_iccm_mem.sv
hdl/ccm_mem_top.sv
testbench/ccm_sva.sv
testbench/ccm_checker.sv
testbench/tb_ccm_top.sv

//--- hdl/ccm_bank.sv
//**********************************************************
// Single bank, one write port and one registered read port
// Read during write of the same row returns the old word
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_bank #(
   parameter int  DEPTH = 256,             // Rows in this bank
   localparam int ROW_W = $clog2(DEPTH)
) (
   input  logic                   clk,
   input  logic                   arst_n,

   // Write port
   input  logic                   wren,
   input  logic [ROW_W-1:0]       wr_row,
   input  logic [`CCM_WORD_W-1:0] wr_data,

   // Read port, one cycle latency
   input  logic                   rden,
   input  logic [ROW_W-1:0]       rd_row,
   output logic [`CCM_WORD_W-1:0] rd_data
);

   // Storage array
   logic [`CCM_WORD_W-1:0] mem [DEPTH];

   //**********************************************************
   // Write
   //**********************************************************
   always_ff @(posedge clk) begin
      if (wren) begin
         mem[wr_row] <= wr_data;   // Lands at this edge
      end
   end

   //**********************************************************
   // Read register
   //**********************************************************
   // Holds its value until the next enabled read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_data <= '0;
      end else if (rden) begin
         rd_data <= mem[rd_row];   // Old word on a same-row write
      end
   end

endmodule

`default_nettype wire

//--- hdl/ccm_dccm_mem.sv
//**********************************************************
// Banked DCCM with one write and two reads per cycle
// rd_addr_hi must equal rd_addr_lo or the next word (wrapping)
// Freeze blocks read capture so both outputs hold
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_dccm_mem (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                lsu_freeze,  // Hold last read data
   input  ccm_pkg::dccm_req_t  req,
   output ccm_pkg::dccm_rsp_t  rsp
);

   localparam int BANKS   = `CCM_DCCM_BANKS;
   localparam int BANK_W  = $clog2(BANKS);
   localparam int WORD_AW = `CCM_DCCM_ADDR_W - 2;   // Word address width
   localparam int ROW_W   = WORD_AW - BANK_W;
   localparam int DEPTH   = 1 << ROW_W;             // Rows per bank

   // Bank select from the low word address bits
   function automatic logic [BANK_W-1:0] bank_of(input logic [`CCM_DCCM_ADDR_W-1:0] addr);
      return addr[BANK_W+1:2];
   endfunction

   // Row within the bank from the upper bits
   function automatic logic [ROW_W-1:0] row_of(input logic [`CCM_DCCM_ADDR_W-1:0] addr);
      return addr[`CCM_DCCM_ADDR_W-1:BANK_W+2];
   endfunction

   logic [BANK_W-1:0]      wr_bank;
   logic [ROW_W-1:0]       wr_row;
   logic [BANK_W-1:0]      lo_bank;
   logic [ROW_W-1:0]       lo_row;
   logic [BANK_W-1:0]      hi_bank;
   logic [ROW_W-1:0]       hi_row;
   logic                   rd_en;                  // Read accepted this cycle
   logic [BANK_W-1:0]      lo_bank_q;              // Lane steering
   logic [BANK_W-1:0]      hi_bank_q;
   logic [`CCM_WORD_W-1:0] bank_rd_data [BANKS];

   //**********************************************************
   // Address split
   //**********************************************************
   assign wr_bank = bank_of(req.wr_addr);
   assign wr_row  = row_of(req.wr_addr);
   assign lo_bank = bank_of(req.rd_addr_lo);
   assign lo_row  = row_of(req.rd_addr_lo);
   assign hi_bank = bank_of(req.rd_addr_hi);
   assign hi_row  = row_of(req.rd_addr_hi);

   assign rd_en = req.rden & ~lsu_freeze;   // No capture while frozen

   //**********************************************************
   // Banks
   //**********************************************************
   for (genvar b = 0; b < BANKS; b++) begin : gen_bank
      logic             bank_wren;
      logic             bank_rden;
      logic [ROW_W-1:0] bank_rd_row;

      assign bank_wren = req.wren & (wr_bank == BANK_W'(b));

      // Only the banks touched by lo or hi read
      assign bank_rden = rd_en & ((lo_bank == BANK_W'(b)) | (hi_bank == BANK_W'(b)));

      // Lo and hi never share a bank unless they are the same word
      assign bank_rd_row = (hi_bank == BANK_W'(b)) ? hi_row : lo_row;

      ccm_bank #(
         .DEPTH   (DEPTH)
      ) bank (
         .clk     (clk),
         .arst_n  (arst_n),
         .wren    (bank_wren),
         .wr_row  (wr_row),
         .wr_data (req.wr_data),
         .rden    (bank_rden),
         .rd_row  (bank_rd_row),
         .rd_data (bank_rd_data[b])
      );
   end

   //**********************************************************
   // Lane steering
   //**********************************************************
   // Same enable as the banks so lanes hold together
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lo_bank_q <= '0;
         hi_bank_q <= '0;
      end else if (rd_en) begin
         lo_bank_q <= lo_bank;
         hi_bank_q <= hi_bank;
      end
   end

   assign rsp.rd_data_lo = bank_rd_data[lo_bank_q];
   assign rsp.rd_data_hi = bank_rd_data[hi_bank_q];

endmodule

`default_nettype wire

//--- hdl/ccm_iccm_mem.sv
//**********************************************************
// Banked ICCM, one or two word writes, four word reads
// Reads and double writes wrap at the end of the memory
// A write wins over a read in the same cycle
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_iccm_mem (
   input  logic                clk,
   input  logic                arst_n,
   input  ccm_pkg::iccm_req_t  req,
   output ccm_pkg::iccm_rsp_t  rsp
);

   import ccm_pkg::*;

   localparam int BANKS   = `CCM_ICCM_BANKS;
   localparam int BANK_W  = $clog2(BANKS);
   localparam int WORD_AW = `CCM_ICCM_ADDR_W - 2;
   localparam int ROW_W   = WORD_AW - BANK_W;
   localparam int DEPTH   = 1 << ROW_W;

   logic [BANK_W-1:0]      start_bank;     // Bank of rw_addr
   logic [ROW_W-1:0]       row;            // Row of rw_addr
   logic [ROW_W-1:0]       next_row;       // Wraps at the last row
   logic [BANK_W-1:0]      hi_bank;        // Bank of the second write word
   logic [ROW_W-1:0]       hi_row;
   logic                   wr_dword;
   logic                   rd_en;
   logic [BANK_W-1:0]      start_bank_q;   // Rotation for the outputs
   logic [`CCM_WORD_W-1:0] bank_rd_data [BANKS];

   //**********************************************************
   // Address split
   //**********************************************************
   assign start_bank = req.rw_addr[BANK_W+1:2];
   assign row        = req.rw_addr[`CCM_ICCM_ADDR_W-1:BANK_W+2];
   assign next_row   = row + 1'b1;
   assign hi_bank    = start_bank + 1'b1;                        // Mod BANKS
   assign hi_row     = (hi_bank == '0) ? next_row : row;          // Crossed a row
   assign wr_dword   = (req.wr_size == ICCM_WR_DWORD);

   assign rd_en = req.rden & ~req.wren;   // Read dropped under a write

   //**********************************************************
   // Banks
   //**********************************************************
   for (genvar b = 0; b < BANKS; b++) begin : gen_bank
      logic                   wr_lo_hit;
      logic                   wr_hi_hit;
      logic                   bank_wren;
      logic [ROW_W-1:0]       bank_wr_row;
      logic [`CCM_WORD_W-1:0] bank_wr_data;
      logic [ROW_W-1:0]       bank_rd_row;

      assign wr_lo_hit = req.wren & (start_bank == BANK_W'(b));
      assign wr_hi_hit = req.wren & wr_dword & (hi_bank == BANK_W'(b));
      assign bank_wren = wr_lo_hit | wr_hi_hit;

      // Low word to the start bank, high word to the next one
      assign bank_wr_row  = wr_lo_hit ? row : hi_row;
      assign bank_wr_data = wr_lo_hit ? req.wr_data[`CCM_WORD_W-1:0]
                                      : req.wr_data[2*`CCM_WORD_W-1:`CCM_WORD_W];

      // Banks below the start bank hold the words of the next row
      assign bank_rd_row = (BANK_W'(b) < start_bank) ? next_row : row;

      ccm_bank #(
         .DEPTH   (DEPTH)
      ) bank (
         .clk     (clk),
         .arst_n  (arst_n),
         .wren    (bank_wren),
         .wr_row  (bank_wr_row),
         .wr_data (bank_wr_data),
         .rden    (rd_en),
         .rd_row  (bank_rd_row),
         .rd_data (bank_rd_data[b])
      );
   end

   //**********************************************************
   // Output rotation
   //**********************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start_bank_q <= '0;
      end else if (rd_en) begin
         start_bank_q <= start_bank;
      end
   end

   // Word i comes from bank start+i, wrapping over the banks
   for (genvar i = 0; i < BANKS; i++) begin : gen_rot
      assign rsp.rd_data[i*`CCM_WORD_W +: `CCM_WORD_W] =
         bank_rd_data[start_bank_q + BANK_W'(i)];
   end

endmodule

`default_nettype wire

//--- hdl/ccm_mem_top.sv
//**********************************************************
// Tightly coupled memory block, DCCM plus ICCM
// Both paths have a fixed one cycle read latency, no stall
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_mem_top (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                lsu_freeze,

   // DCCM port
   input  ccm_pkg::dccm_req_t  dccm_req,
   output ccm_pkg::dccm_rsp_t  dccm_rsp,

   // ICCM port
   input  ccm_pkg::iccm_req_t  iccm_req,
   output ccm_pkg::iccm_rsp_t  iccm_rsp
);

   //**********************************************************
   // DCCM
   //**********************************************************
   if (`CCM_DCCM_ENABLE) begin : gen_dccm_enable
      ccm_dccm_mem dccm (
         .clk        (clk),
         .arst_n     (arst_n),
         .lsu_freeze (lsu_freeze),
         .req        (dccm_req),
         .rsp        (dccm_rsp)
      );
   end else begin : gen_dccm_disable
      assign dccm_rsp = '0;   // No DCCM built
   end

   //**********************************************************
   // ICCM
   //**********************************************************
   ccm_iccm_mem iccm (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (iccm_req),
      .rsp    (iccm_rsp)
   );

endmodule

`default_nettype wire

//--- hdl/ccm_params.svh
//**********************************************************
// Sizes of the tightly coupled memories
// Bank counts must be powers of two and divide the word count
// Set CCM_DCCM_ENABLE to 0 to build without a DCCM
//**********************************************************

`ifndef CCM_PARAMS_SVH
`define CCM_PARAMS_SVH

// Stored word, 32 data bits plus 7 check bits
`define CCM_WORD_W 39

// DCCM byte address, 4 KB
`define CCM_DCCM_ADDR_W 12

// ICCM byte address, word addressed on bits 11:2
`define CCM_ICCM_ADDR_W 12

// Banks per memory, selected by low word address bits
`define CCM_DCCM_BANKS 4
`define CCM_ICCM_BANKS 4

// DCCM build enable (1 builds it, 0 ties read data low)
`define CCM_DCCM_ENABLE 1

`endif

//--- hdl/ccm_pkg.sv
//**********************************************************
// Request and response types of the CCM block
// Check bits travel inside each word and are never decoded
//**********************************************************

`default_nettype none

`include "ccm_params.svh"

package ccm_pkg;

   // ICCM write size
   typedef enum logic {
      ICCM_WR_WORD  = 1'b0, // One word at rw_addr
      ICCM_WR_DWORD = 1'b1  // Two words, rw_addr and the next
   } iccm_wr_size_e;

   //**********************************************************
   // DCCM
   //**********************************************************
   typedef struct packed {
      logic                        wren;       // Word write
      logic                        rden;       // Dual read
      logic [`CCM_DCCM_ADDR_W-1:0] wr_addr;    // Byte address
      logic [`CCM_DCCM_ADDR_W-1:0] rd_addr_lo; // Low word
      logic [`CCM_DCCM_ADDR_W-1:0] rd_addr_hi; // Same or next word
      logic [`CCM_WORD_W-1:0]      wr_data;    // Data plus check bits
   } dccm_req_t;

   typedef struct packed {
      logic [`CCM_WORD_W-1:0] rd_data_lo;
      logic [`CCM_WORD_W-1:0] rd_data_hi;
   } dccm_rsp_t;

   //**********************************************************
   // ICCM
   //**********************************************************
   typedef struct packed {
      logic                          wren;
      logic                          rden;
      logic [`CCM_ICCM_ADDR_W-1:2]   rw_addr;  // Word address
      iccm_wr_size_e                 wr_size;
      logic [2*`CCM_WORD_W-1:0]      wr_data;  // Low word at rw_addr
   } iccm_req_t;

   // Word 0 in the low bits is the word at rw_addr
   typedef struct packed {
      logic [`CCM_ICCM_BANKS*`CCM_WORD_W-1:0] rd_data;
   } iccm_rsp_t;

endpackage

`default_nettype wire

//--- run_ccm.sh
#!/bin/sh
# Build and run the CCM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f ccm_mem.f --top-module tb_ccm_top -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_ccm_top +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# The log decides the result
if grep -q "^TEST PASSED$" sim.log; then
   exit 0
fi
exit 1

//--- testbench/ccm_checker.sv
//**********************************************************
// Reference model of both memories that checks every read
// Only words written since reset are compared
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_checker (
   input logic               clk,
   input logic               arst_n,
   input logic               lsu_freeze,
   input ccm_pkg::dccm_req_t dccm_req,
   input ccm_pkg::dccm_rsp_t dccm_rsp,
   input ccm_pkg::iccm_req_t iccm_req,
   input ccm_pkg::iccm_rsp_t iccm_rsp
);

   import ccm_pkg::*;

   localparam int W     = `CCM_WORD_W;
   localparam int D_AW  = `CCM_DCCM_ADDR_W - 2;   // DCCM word address
   localparam int I_AW  = `CCM_ICCM_ADDR_W - 2;
   localparam int LANES = `CCM_ICCM_BANKS;

   logic [W-1:0]    dccm_mem [1 << D_AW];
   logic            dccm_vld [1 << D_AW];   // Word written since reset
   logic [W-1:0]    iccm_mem [1 << I_AW];
   logic            iccm_vld [1 << I_AW];
   logic [W-1:0]    exp_lo;
   logic [W-1:0]    exp_hi;
   logic            exp_lo_vld;
   logic            exp_hi_vld;
   logic [W-1:0]    exp_i [LANES];
   logic            exp_i_vld [LANES];
   logic [D_AW-1:0] d_idx;
   logic [I_AW-1:0] i_idx;
   logic            armed = 1'b0;            // Set once out of reset
   int              check_count = 0;
   int              error_count = 0;

   task automatic compare_word(input string name, input logic [W-1:0] exp,
                               input logic vld, input logic [W-1:0] act);
      if (vld) begin
         check_count++;
         if (act !== exp) begin
            error_count++;
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
         end
      end
   endtask

   //**********************************************************
   // Model update at the clock edge
   //**********************************************************
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         armed      = 1'b0;
         exp_lo     = '0;   // Outputs cleared by reset
         exp_hi     = '0;
         exp_lo_vld = 1'b1;
         exp_hi_vld = 1'b1;
         for (int l = 0; l < LANES; l++) begin
            exp_i[l]     = '0;
            exp_i_vld[l] = 1'b1;
         end
         for (int i = 0; i < (1 << D_AW); i++) begin
            dccm_vld[i] = 1'b0;
         end
         for (int i = 0; i < (1 << I_AW); i++) begin
            iccm_vld[i] = 1'b0;
         end
      end else begin
         armed = 1'b1;
         // Reads see the memory before this edge's write
         if (dccm_req.rden && !lsu_freeze && `CCM_DCCM_ENABLE != 0) begin
            d_idx      = dccm_req.rd_addr_lo[`CCM_DCCM_ADDR_W-1:2];
            exp_lo     = dccm_mem[d_idx];
            exp_lo_vld = dccm_vld[d_idx];
            d_idx      = dccm_req.rd_addr_hi[`CCM_DCCM_ADDR_W-1:2];
            exp_hi     = dccm_mem[d_idx];
            exp_hi_vld = dccm_vld[d_idx];
         end
         if (dccm_req.wren) begin
            d_idx           = dccm_req.wr_addr[`CCM_DCCM_ADDR_W-1:2];
            dccm_mem[d_idx] = dccm_req.wr_data;
            dccm_vld[d_idx] = 1'b1;
         end
         if (iccm_req.rden && !iccm_req.wren) begin
            for (int l = 0; l < LANES; l++) begin
               i_idx        = iccm_req.rw_addr + I_AW'(l);   // Wraps
               exp_i[l]     = iccm_mem[i_idx];
               exp_i_vld[l] = iccm_vld[i_idx];
            end
         end
         if (iccm_req.wren) begin
            i_idx           = iccm_req.rw_addr;
            iccm_mem[i_idx] = iccm_req.wr_data[W-1:0];
            iccm_vld[i_idx] = 1'b1;
            if (iccm_req.wr_size == ICCM_WR_DWORD) begin
               i_idx           = i_idx + I_AW'(1);   // Last word wraps to 0
               iccm_mem[i_idx] = iccm_req.wr_data[2*W-1:W];
               iccm_vld[i_idx] = 1'b1;
            end
         end
      end
   end

   // Outputs are settled mid cycle
   always @(negedge clk) begin
      if (armed && arst_n) begin
         compare_word("dccm_rsp.rd_data_lo", exp_lo, exp_lo_vld, dccm_rsp.rd_data_lo);
         compare_word("dccm_rsp.rd_data_hi", exp_hi, exp_hi_vld, dccm_rsp.rd_data_hi);
         for (int l = 0; l < LANES; l++) begin
            compare_word($sformatf("iccm_rsp.rd_data[%0d]", l), exp_i[l], exp_i_vld[l],
                         iccm_rsp.rd_data[l*W +: W]);
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/ccm_sva.sv
//**********************************************************
// Bound checks on the CCM top level ports
// The DCCM address rule applies only while rden is high
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module ccm_sva (
   input logic               clk,
   input logic               arst_n,
   input logic               lsu_freeze,
   input ccm_pkg::dccm_req_t dccm_req,
   input ccm_pkg::dccm_rsp_t dccm_rsp,
   input ccm_pkg::iccm_req_t iccm_req,
   input ccm_pkg::iccm_rsp_t iccm_rsp
);

   import ccm_pkg::*;

   localparam int WORD_AW = `CCM_DCCM_ADDR_W - 2;

   int                 fail_count = 0;
   logic [WORD_AW-1:0] lo_word;
   logic [WORD_AW-1:0] hi_word;
   logic [WORD_AW-1:0] lo_next;   // Wraps at the last word

   assign lo_word = dccm_req.rd_addr_lo[`CCM_DCCM_ADDR_W-1:2];
   assign hi_word = dccm_req.rd_addr_hi[`CCM_DCCM_ADDR_W-1:2];
   assign lo_next = lo_word + WORD_AW'(1);

   // High read is the same word or the next one
   hi_addr_rule: assert property (@(posedge clk) disable iff (!arst_n)
      dccm_req.rden |-> (hi_word == lo_word) || (hi_word == lo_next))
      else begin
         fail_count++;
         $error("DCCM high read address breaks the lo/hi rule");
      end

   // Read outputs are cleared by reset
   rst_outputs_zero: assert property (@(posedge clk)
      !arst_n |-> (dccm_rsp == '0) && (iccm_rsp == '0))
      else begin
         fail_count++;
         $error("read outputs not zero in reset");
      end

   // Outputs hold without an accepted read
   dccm_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (!dccm_req.rden || lsu_freeze) |=> $stable(dccm_rsp))
      else begin
         fail_count++;
         $error("DCCM outputs changed without an accepted read");
      end

   iccm_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (!iccm_req.rden || iccm_req.wren) |=> $stable(iccm_rsp))
      else begin
         fail_count++;
         $error("ICCM outputs changed without an accepted read");
      end

endmodule

bind ccm_mem_top ccm_sva sva (
   .clk        (clk),
   .arst_n     (arst_n),
   .lsu_freeze (lsu_freeze),
   .dccm_req   (dccm_req),
   .dccm_rsp   (dccm_rsp),
   .iccm_req   (iccm_req),
   .iccm_rsp   (iccm_rsp)
);

`default_nettype wire

//--- testbench/tb_ccm_top.sv
//**********************************************************
// Seeded random test of the CCM block in six phases
// Addresses come from the first and last 16 words only
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ccm_params.svh"

module tb_ccm_top;

   import ccm_pkg::*;

   localparam int PHASES    = 6;
   localparam int PHASE_OPS = 300;
   localparam int RST_CYC   = 5;
   localparam int MAX_CYC   = PHASES * PHASE_OPS + RST_CYC + 100;

   logic      clk;
   logic      arst_n;
   logic      lsu_freeze;
   dccm_req_t dccm_req;
   dccm_rsp_t dccm_rsp;
   iccm_req_t iccm_req;
   iccm_rsp_t iccm_rsp;
   integer    seed;
   logic [9:0] last_wa;        // Previous DCCM write word
   int        cycles = 0;
   int        errs_before;
   int        checks_before;
   string     phase_name [PHASES] = '{"dccm_rw", "dccm_pair", "dccm_freeze",
                                      "iccm_wr_rd", "iccm_wr_wins", "mixed"};

   ccm_mem_top uut (
      .clk        (clk),
      .arst_n     (arst_n),
      .lsu_freeze (lsu_freeze),
      .dccm_req   (dccm_req),
      .dccm_rsp   (dccm_rsp),
      .iccm_req   (iccm_req),
      .iccm_rsp   (iccm_rsp)
   );

   ccm_checker chk (
      .clk        (clk),
      .arst_n     (arst_n),
      .lsu_freeze (lsu_freeze),
      .dccm_req   (dccm_req),
      .dccm_rsp   (dccm_rsp),
      .iccm_req   (iccm_req),
      .iccm_rsp   (iccm_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Words near both ends so wraps occur
   function automatic logic [9:0] pick_word();
      logic [31:0] r;
      r = $random(seed);
      return r[4] ? {6'h3f, r[3:0]} : {6'h00, r[3:0]};
   endfunction

   function automatic logic [`CCM_WORD_W-1:0] rand_word();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[`CCM_WORD_W-1:0];
   endfunction

   task automatic idle_inputs();
      lsu_freeze = 1'b0;
      dccm_req   = '0;
      iccm_req   = '0;
   endtask

   //**********************************************************
   // One request per cycle, shaped by the phase
   //**********************************************************
   task automatic drive_op(input int phase);
      logic [31:0] r;
      logic [9:0]  wa;
      logic [9:0]  ra;
      idle_inputs();
      r  = $random(seed);
      wa = pick_word();
      ra = (phase == 1) ? (r[4] ? wa : last_wa) : pick_word();   // wa hits the write
      dccm_req.wr_addr    = {wa, 2'b00};
      dccm_req.wr_data    = rand_word();
      dccm_req.rd_addr_lo = {ra, 2'b00};
      dccm_req.rd_addr_hi = {ra + 10'd1, 2'b00};                 // Next word by default
      iccm_req.rw_addr    = pick_word();
      iccm_req.wr_size    = r[6] ? ICCM_WR_DWORD : ICCM_WR_WORD;
      iccm_req.wr_data    = {rand_word(), rand_word()};
      case (phase)
         1: begin
            dccm_req.wren       = r[0] | r[1];
            dccm_req.rden       = r[2] | r[3];
            dccm_req.rd_addr_hi = {ra, 2'b00};
         end
         2: begin
            dccm_req.wren = r[0];
            dccm_req.rden = 1'b1;
         end
         3: begin
            dccm_req.wren = r[0];
            dccm_req.rden = r[2] | r[3];
            lsu_freeze    = r[1];
            if (r[5]) dccm_req.rd_addr_hi = {ra, 2'b00};
         end
         4: begin
            iccm_req.wren = r[0];
            iccm_req.rden = ~r[0];
         end
         5: begin
            iccm_req.wren = r[0];
            iccm_req.rden = r[1] | r[2];   // Often both high
         end
         default: begin
            dccm_req.wren = r[0];
            dccm_req.rden = r[1];
            lsu_freeze    = r[2] & r[7];
            iccm_req.wren = r[3];
            iccm_req.rden = r[5];
         end
      endcase
      last_wa = wa;
   endtask

   // Cycle limit from the phase lengths
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYC);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      seed    = 61083;
      last_wa = '0;
      idle_inputs();
      arst_n = 1'b0;
      repeat (RST_CYC) @(negedge clk);
      arst_n = 1'b1;
      for (int p = 1; p <= PHASES; p++) begin
         errs_before   = chk.error_count;
         checks_before = chk.check_count;
         repeat (PHASE_OPS) begin
            @(negedge clk);
            drive_op(p);
         end
         @(negedge clk);
         idle_inputs();
         @(posedge clk);   // Last read compared at the negedge before
         $display("phase %0d %s: %0d checks, %0d errors", p, phase_name[p-1],
                  chk.check_count - checks_before, chk.error_count - errs_before);
      end
      $display("total: %0d checks, %0d mismatches, %0d assertion failures",
               chk.check_count, chk.error_count, uut.sva.fail_count);
      if (chk.check_count == 0) $display("no read was compared against the model");
      if (chk.error_count == 0 && uut.sva.fail_count == 0 && chk.check_count > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
